// ==== router_top.f ====
design/router_pkg.sv
design/route_if.sv
design/route_table.sv
design/route_lookup.sv
design/router_top.sv
bench/router_tb.sv

// ==== Bender.yml ====
package:
  name: router_top

sources:
  - files:
      - design/router_pkg.sv
      - design/route_if.sv
      - design/route_table.sv
      - design/route_lookup.sv
      - design/router_top.sv
  - target: test
    files:
      - bench/router_tb.sv

// ==== bench/router_tb.sv ====
// testbench for the router, with strobe config tasks, packet tasks,
// an output monitor, compare tasks and the directed tests
`timescale 1ns/1ns
`default_nettype none

module router_tb import router_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 3000;       // all tests take a few hundred

    typedef struct {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        meta;                      // first beat of a packet
        rtl_port_e   ing;
        rtl_port_e   egr;
        int          cyc;                       // negedge where the beat shows
    } beat_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [63:0] in_data;
    logic [7:0]  in_keep;
    logic        in_last;
    logic [3:0]  in_ing_port;
    logic        out_valid;
    logic [63:0] out_data;
    logic [7:0]  out_keep;
    logic        out_last;
    logic [3:0]  out_ing_port;
    logic [3:0]  out_egr_port;
    logic        out_meta_valid;
    logic        cfg_wr;
    logic        cfg_rd;
    logic [4:0]  cfg_addr;
    logic [15:0] cfg_wdata;
    logic [15:0] cfg_rdata;
    logic        cfg_rvalid;
    logic        cfg_err;

    int          cyc = 0;
    int          n_errors = 0;
    logic [15:0] n_dropped = '0;                // packets dropped since last clear
    logic [31:0] lfsr = 32'h541d;
    string       cur_test = "reset";
    beat_t       exp_q[$];
    beat_t       got_q[$];

    router_top i_router_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("run timed out after %0d cycles", cyc));
        end
    end

    ////////////////////
    // helpers

    task automatic fail_run(input string msg);
        n_errors++;
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32,22,2,1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], next_bit()};          // one step per bit
        end
        return v;
    endfunction

    ////////////////////
    // compare tasks

    task automatic check_beat(input beat_t exp, input beat_t act);
        if (exp.data !== act.data || exp.keep !== act.keep || exp.last !== act.last) begin
            fail_run($sformatf("[FAIL] %s: beat expected %h/%h/%b actual %h/%h/%b",
                cur_test, exp.data, exp.keep, exp.last, act.data, act.keep, act.last));
        end
    endtask

    task automatic check_port(input string what, input rtl_port_e exp, input rtl_port_e act);
        if (exp !== act) begin
            fail_run($sformatf("[FAIL] %s: %s expected %0d actual %0d",
                cur_test, what, exp, act));
        end
    endtask

    task automatic check_word(input string what, input logic [15:0] exp,
                              input logic [15:0] act);
        if (exp !== act) begin
            fail_run($sformatf("[FAIL] %s: %s expected %h actual %h",
                cur_test, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("[FAIL] %s: %s expected %b actual %b",
                cur_test, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) begin
            fail_run($sformatf("[FAIL] %s: %s expected %0d actual %0d",
                cur_test, what, exp, act));
        end
    endtask

    ////////////////////
    // drivers and monitor

    task automatic cfg_write(input logic [4:0] addr, input logic [15:0] data,
                             output logic err);
        @(negedge clk);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_wr = 1'b0;
        err    = cfg_err;                       // pulse follows the strobe edge
        @(negedge clk);
        check_flag("cfg_err after one cycle", 1'b0, cfg_err);
    endtask

    task automatic cfg_read(input logic [4:0] addr, output logic [15:0] data,
                            output logic err);
        @(negedge clk);
        cfg_rd   = 1'b1;
        cfg_addr = addr;
        @(negedge clk);
        cfg_rd = 1'b0;
        check_flag("cfg_rvalid one cycle after cfg_rd", 1'b1, cfg_rvalid);
        data = cfg_rdata;
        err  = cfg_err;
        @(negedge clk);
        check_flag("cfg_rvalid after one cycle", 1'b0, cfg_rvalid);
        check_flag("cfg_err after one cycle", 1'b0, cfg_err);
    endtask

    task automatic send_packet(input logic [3:0] ing, input logic [3:0] key, input int beats,
                               input logic fwd, input rtl_port_e egr);
        beat_t b;
        for (int i = 0; i < beats; i++) begin
            @(negedge clk);
            b.data = rand_bits(64);
            if (i == 0) begin
                b.data[3:0] = key;              // route index in byte 0
            end
            b.last = i == beats - 1;
            b.keep = b.last ? 8'hFF >> rand_bits(3) : 8'hFF;
            b.meta = i == 0;
            b.ing  = rtl_port_e'(ing);
            b.egr  = egr;
            b.cyc  = cyc + 2;                   // two cycles through the pipeline
            in_valid    = 1'b1;
            in_data     = b.data;
            in_keep     = b.keep;
            in_last     = b.last;
            in_ing_port = ing;
            if (fwd) begin
                exp_q.push_back(b);
            end
        end
        if (!fwd) begin
            n_dropped++;
        end
    endtask

    task automatic collect_beats();
        beat_t b;
        forever begin
            @(negedge clk);
            if (out_valid) begin
                b.data = out_data;
                b.keep = out_keep;
                b.last = out_last;
                b.meta = out_meta_valid;
                b.ing  = rtl_port_e'(out_ing_port);
                b.egr  = rtl_port_e'(out_egr_port);
                b.cyc  = cyc;
                got_q.push_back(b);
            end else if (out_meta_valid) begin
                fail_run("out_meta_valid was high while out_valid was low");
            end
        end
    endtask

    task automatic drain_and_compare();
        @(negedge clk);
        in_valid = 1'b0;
        repeat (3) @(negedge clk);              // pipeline empty by now
        check_count("output beats", exp_q.size(), got_q.size());
        foreach (exp_q[i]) begin
            check_count("beat cycle", exp_q[i].cyc, got_q[i].cyc);
            check_beat(exp_q[i], got_q[i]);
            check_flag("out_meta_valid", exp_q[i].meta, got_q[i].meta);
            if (exp_q[i].meta) begin
                check_port("out_ing_port", exp_q[i].ing, got_q[i].ing);
                check_port("out_egr_port", exp_q[i].egr, got_q[i].egr);
            end
        end
        exp_q.delete();
        got_q.delete();
    endtask

    ////////////////////
    // tests

    task automatic test_table_access();
        logic [4:0]  addrs [6] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd7};
        logic [15:0] vals  [6] = '{16'h0151, 16'h0100, 16'h0028,   // ecg1, cpu, off
                                   16'h0121, 16'h013C, 16'h015A};  // id 33, hdr0, 0x5a
        logic [15:0] rd;
        logic        err;
        cur_test = "table_access";
        cfg_read(CFG_ADDR_DROP_CNT, rd, err);
        check_word("drop count after reset", 16'd0, rd);
        foreach (addrs[i]) begin
            cfg_write(addrs[i], vals[i], err);
            check_flag("cfg_err on mapped write", 1'b0, err);
        end
        foreach (addrs[i]) begin
            cfg_read(addrs[i], rd, err);
            check_word("entry read back", vals[i], rd);
            check_flag("cfg_err on mapped read", 1'b0, err);
        end
        cfg_read(5'd20, rd, err);
        check_flag("cfg_err on unmapped read", 1'b1, err);
        check_word("unmapped read data", 16'd0, rd);
        cfg_write(5'd20, 16'h1234, err);
        check_flag("cfg_err on unmapped write", 1'b1, err);
    endtask

    task automatic test_forwarding();
        cur_test = "forwarding";
        send_packet(cpu, 4'd1, 1, 1'b1, ecg1);
        send_packet(oisl0, 4'd1, 4, 1'b1, ecg1);
        send_packet(ecp1, 4'd2, 4, 1'b1, cpu);
        send_packet(hdr1, 4'd2, 1, 1'b1, cpu);
        drain_and_compare();
    endtask

    task automatic test_drop_rules();
        cur_test = "drop_rules";
        send_packet(cpu, 4'd3, 2, 1'b0, cpu);   // disabled entry
        send_packet(4'd12, 4'd1, 1, 1'b0, cpu); // unknown ingress
        send_packet(cpu, 4'd4, 3, 1'b0, cpu);   // entry holds id 33
        send_packet(hdr0, 4'd5, 2, 1'b0, cpu);  // hairpin
        drain_and_compare();
    endtask

    task automatic test_drop_counter();
        logic [15:0] rd;
        logic        err;
        cur_test = "drop_counter";
        cfg_read(CFG_ADDR_DROP_CNT, rd, err);
        check_word("drop count", n_dropped, rd);
        cfg_write(CFG_ADDR_DROP_CNT, 16'hFFFF, err);
        n_dropped = '0;
        cfg_read(CFG_ADDR_DROP_CNT, rd, err);
        check_word("drop count after clear", 16'd0, rd);
    endtask

    task automatic test_back_to_back();
        logic [15:0] rd;
        logic        err;
        cur_test = "back_to_back";
        send_packet(oisl1, 4'd1, 3, 1'b1, ecg1);
        send_packet(ecg0, 4'd3, 2, 1'b0, cpu);  // disabled, two beats
        send_packet(ecg2, 4'd2, 1, 1'b1, cpu);
        send_packet(4'd12, 4'd2, 1, 1'b0, cpu);
        send_packet(cpu, 4'd5, 4, 1'b1, hdr0);
        send_packet(hdr0, 4'd5, 1, 1'b0, cpu);  // hairpin
        send_packet(ecg3, 4'd1, 2, 1'b1, ecg1);
        drain_and_compare();
        cfg_read(CFG_ADDR_DROP_CNT, rd, err);
        check_word("drop count", n_dropped, rd);
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_keep     = '0;
        in_last     = 1'b0;
        in_ing_port = '0;
        cfg_wr      = 1'b0;
        cfg_rd      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fork
            collect_beats();
        join_none
        test_table_access();
        test_forwarding();
        test_drop_rules();
        test_drop_counter();
        test_back_to_back();
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/router_top.sv ====
// router top level with route table and lookup pipeline
`timescale 1ns/1ns
`default_nettype none

module router_top (
    input  logic        clk,
    input  logic        rst_n,

    // packet in
    input  logic        in_valid,
    input  logic [63:0] in_data,
    input  logic [7:0]  in_keep,
    input  logic        in_last,
    input  logic [3:0]  in_ing_port,

    // packet out
    output logic        out_valid,
    output logic [63:0] out_data,
    output logic [7:0]  out_keep,
    output logic        out_last,
    output logic [3:0]  out_ing_port,
    output logic [3:0]  out_egr_port,
    output logic        out_meta_valid,

    // config strobes
    input  logic        cfg_wr,
    input  logic        cfg_rd,
    input  logic [4:0]  cfg_addr,
    input  logic [15:0] cfg_wdata,
    output logic [15:0] cfg_rdata,
    output logic        cfg_rvalid,
    output logic        cfg_err
);

    route_if rt ();                             // key, entry, drop

    route_table i_route_table (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cfg_wr     ( cfg_wr     ),
        .cfg_rd     ( cfg_rd     ),
        .cfg_addr   ( cfg_addr   ),
        .cfg_wdata  ( cfg_wdata  ),
        .cfg_rdata  ( cfg_rdata  ),
        .cfg_rvalid ( cfg_rvalid ),
        .cfg_err    ( cfg_err    ),
        .rt         ( rt.tbl     )
    );

    route_lookup i_route_lookup (
        .clk            ( clk            ),
        .rst_n          ( rst_n          ),
        .in_valid       ( in_valid       ),
        .in_data        ( in_data        ),
        .in_keep        ( in_keep        ),
        .in_last        ( in_last        ),
        .in_ing_port    ( in_ing_port    ),
        .out_valid      ( out_valid      ),
        .out_data       ( out_data       ),
        .out_keep       ( out_keep       ),
        .out_last       ( out_last       ),
        .out_ing_port   ( out_ing_port   ),
        .out_egr_port   ( out_egr_port   ),
        .out_meta_valid ( out_meta_valid ),
        .rt             ( rt.lookup      )
    );

endmodule

`default_nettype wire

// ==== design/route_lookup.sv ====
// two stage packet pipeline with port translation, route lookup
// and whole packet drop
`timescale 1ns/1ns
`default_nettype none

module route_lookup import router_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [63:0] in_data,
    input  logic [7:0]  in_keep,
    input  logic        in_last,
    input  logic [3:0]  in_ing_port,
    output logic        out_valid,
    output logic [63:0] out_data,
    output logic [7:0]  out_keep,
    output logic        out_last,
    output logic [3:0]  out_ing_port,
    output logic [3:0]  out_egr_port,
    output logic        out_meta_valid,
    route_if.lookup     rt
);

    logic        in_pkt;                        // inside a packet on input
    logic        in_first;

    logic        s1_valid;
    logic        s1_first;
    logic [63:0] s1_data;
    logic [7:0]  s1_keep;
    logic        s1_last;
    logic [3:0]  s1_key;
    logic [7:0]  s1_ing_p4;
    logic [3:0]  s1_ing_port;

    logic [3:0]  egr_port;
    logic        drop_now;                      // decision for a first beat
    logic        drop_cur;                      // decision for this beat
    logic        pkt_drop;                      // held across the packet

    ////////////////////
    // stage 1

    assign in_first = in_valid && !in_pkt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
        end else begin
            if (in_valid) begin
                in_pkt <= !in_last;             // closes on last beat
            end
            s1_valid <= in_valid;
            s1_first <= in_first;
        end
    end

    always_ff @(posedge clk) begin
        s1_data <= in_data;
        s1_keep <= in_keep;
        s1_last <= in_last;
        if (in_first) begin
            s1_key      <= in_data[3:0];        // low nibble of byte 0
            s1_ing_p4   <= ingress_to_p4(in_ing_port);
            s1_ing_port <= in_ing_port;
        end
    end

    ////////////////////
    // stage 2

    assign rt.key   = s1_key;
    assign egr_port = p4_to_egress(rt.entry.egr_id);

    assign drop_now = s1_ing_p4 == P4_ID_NONE
                   || !rt.entry.en
                   || egr_port == RTL_PORT_NONE
                   || egr_port == s1_ing_port;  // hairpin

    assign drop_cur = s1_first ? drop_now : pkt_drop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_drop       <= 1'b0;
            out_valid      <= 1'b0;
            out_meta_valid <= 1'b0;
            rt.drop        <= 1'b0;
        end else begin
            if (s1_valid) begin
                pkt_drop <= s1_last ? 1'b0 : drop_cur;
            end
            out_valid      <= s1_valid && !drop_cur;
            out_meta_valid <= s1_valid && s1_first && !drop_now;
            rt.drop        <= s1_valid && s1_first && drop_now;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= s1_data;
        out_keep <= s1_keep;
        out_last <= s1_last;
        if (s1_first) begin
            out_ing_port <= s1_ing_port;        // original rtl number
            out_egr_port <= egr_port;
        end
    end

endmodule

`default_nettype wire

// ==== design/route_table.sv ====
// route entry registers, drop counter and strobe register access
`timescale 1ns/1ns
`default_nettype none

module route_table import router_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_wr,
    input  logic        cfg_rd,
    input  logic [4:0]  cfg_addr,
    input  logic [15:0] cfg_wdata,
    output logic [15:0] cfg_rdata,
    output logic        cfg_rvalid,
    output logic        cfg_err,
    route_if.tbl        rt
);

    route_entry_t entries [NUM_ROUTES];
    logic [15:0]  drop_cnt;
    cfg_op_e      op;
    logic         is_entry;                     // addr hits route table
    logic         addr_ok;
    logic [15:0]  rd_word;

    ////////////////////
    // strobe decode

    always_comb begin
        if (cfg_wr) begin
            op = write;                         // write wins a collision
        end else if (cfg_rd) begin
            op = read;
        end else begin
            op = idle;
        end
    end

    assign is_entry = cfg_addr < 5'(NUM_ROUTES);
    assign addr_ok  = cfg_addr <= CFG_ADDR_LAST;

    ////////////////////
    // storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ROUTES; i++) begin
                entries[i] <= '0;               // all routes disabled
            end
        end else if (op == write && is_entry) begin
            entries[cfg_addr[3:0]] <= route_entry_t'(cfg_wdata[8:0]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_cnt <= '0;
        end else if (op == write && cfg_addr == CFG_ADDR_DROP_CNT) begin
            drop_cnt <= '0;                     // clear beats increment
        end else if (rt.drop && drop_cnt != '1) begin
            drop_cnt <= drop_cnt + 16'd1;       // saturating
        end
    end

    assign rt.entry = entries[rt.key];          // old value on same-cycle write

    ////////////////////
    // read back

    always_comb begin
        if (is_entry) begin
            rd_word = {7'd0, entries[cfg_addr[3:0]]};
        end else if (cfg_addr == CFG_ADDR_DROP_CNT) begin
            rd_word = drop_cnt;
        end else begin
            rd_word = '0;                       // unmapped
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rvalid <= 1'b0;
            cfg_err    <= 1'b0;
        end else begin
            cfg_rvalid <= op == read;
            cfg_err    <= op != idle && !addr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (op == read) begin
            cfg_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== design/route_if.sv ====
// lookup to route table interface
`timescale 1ns/1ns
`default_nettype none

interface route_if import router_pkg::*; ();

    logic [3:0]   key;                          // route index from byte 0
    logic         drop;                         // one pulse per dropped packet
    route_entry_t entry;                        // entry for current key

    // pipeline side
    modport lookup (
        output key,
        output drop,
        input  entry
    );

    // register block side
    modport tbl (
        output entry,
        input  key,
        input  drop
    );

endinterface

`default_nettype wire

// ==== design/router_pkg.sv ====
// port enums, P4 id constants, route entry type and register map
// port id translation functions shared by the router blocks
`default_nettype none

package router_pkg;

    ////////////////////
    // port numbering

    typedef enum logic [3:0] {
        cpu,                                    // 0
        oisl0,
        oisl1,
        ecp0,
        ecp1,
        hdr0,
        hdr1,
        ecg0,
        ecg1,
        ecg2,
        ecg3                                    // 10
    } rtl_port_e;

    localparam logic [7:0] CPU_P4_ID   = 8'd0;
    localparam logic [7:0] OISL0_P4_ID = 8'd20;
    localparam logic [7:0] OISL1_P4_ID = 8'd21;
    localparam logic [7:0] ECP0_P4_ID  = 8'd40;
    localparam logic [7:0] ECP1_P4_ID  = 8'd41;
    localparam logic [7:0] HDR0_P4_ID  = 8'd60;
    localparam logic [7:0] HDR1_P4_ID  = 8'd61;
    localparam logic [7:0] ECG0_P4_ID  = 8'd80;
    localparam logic [7:0] ECG1_P4_ID  = 8'd81;
    localparam logic [7:0] ECG2_P4_ID  = 8'd82;
    localparam logic [7:0] ECG3_P4_ID  = 8'd83;

    localparam logic [7:0] P4_ID_NONE    = 8'hFF;  // no such p4 port
    localparam logic [3:0] RTL_PORT_NONE = 4'hF;   // no such rtl port

    ////////////////////
    // route table

    typedef struct packed {
        logic       en;                         // entry valid
        logic [7:0] egr_id;                     // p4 egress id
    } route_entry_t;

    localparam int NUM_ROUTES = 16;

    localparam logic [4:0] CFG_ADDR_DROP_CNT = 5'd16;  // write clears
    localparam logic [4:0] CFG_ADDR_LAST     = 5'd16;  // highest mapped addr

    typedef enum logic [1:0] {
        idle,
        write,
        read
    } cfg_op_e;

    ////////////////////
    // id translation

    function automatic logic [7:0] ingress_to_p4(input logic [3:0] port);
        case (port)
            cpu     : return CPU_P4_ID;
            oisl0   : return OISL0_P4_ID;
            oisl1   : return OISL1_P4_ID;
            ecp0    : return ECP0_P4_ID;
            ecp1    : return ECP1_P4_ID;
            hdr0    : return HDR0_P4_ID;
            hdr1    : return HDR1_P4_ID;
            ecg0    : return ECG0_P4_ID;
            ecg1    : return ECG1_P4_ID;
            ecg2    : return ECG2_P4_ID;
            ecg3    : return ECG3_P4_ID;
            default : return P4_ID_NONE;        // 11..15 unknown
        endcase
    endfunction

    function automatic logic [3:0] p4_to_egress(input logic [7:0] id);
        case (id)
            CPU_P4_ID   : return cpu;
            OISL0_P4_ID : return oisl0;
            OISL1_P4_ID : return oisl1;
            ECP0_P4_ID  : return ecp0;
            ECP1_P4_ID  : return ecp1;
            HDR0_P4_ID  : return hdr0;
            HDR1_P4_ID  : return hdr1;
            ECG0_P4_ID  : return ecg0;
            ECG1_P4_ID  : return ecg1;
            ECG2_P4_ID  : return ecg2;
            ECG3_P4_ID  : return ecg3;
            default     : return RTL_PORT_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire
